/* floo_pkg.sv */
// ---------------------------------------------------------------------------
// Shared definitions of the mesh tile router
// Coordinates, flit formats, port encoding and input buffer sizing for the
// narrow request, narrow response and wide networks
// ---------------------------------------------------------------------------

package floo_pkg;

  // Tile coordinates, x in the low half of the id and y in the high half
  localparam int unsigned coord_w = 3;
  localparam int unsigned id_w    = 2 * coord_w;

  typedef logic [coord_w-1:0] coord_t;
  typedef logic [id_w-1:0]    id_t;

  // Header holds destination id in the low bits, source id above it
  localparam int unsigned hdr_w = 2 * id_w;

  // Payload and full flit widths per network
  localparam int unsigned narrow_payload_w = 32;
  localparam int unsigned wide_payload_w   = 64;
  localparam int unsigned narrow_flit_w    = hdr_w + narrow_payload_w;
  localparam int unsigned wide_flit_w      = hdr_w + wide_payload_w;

  typedef logic [narrow_flit_w-1:0] narrow_flit_t;
  typedef logic [wide_flit_w-1:0]   wide_flit_t;

  // Router ports
  localparam int unsigned num_routes = 5;

  typedef logic [2:0] port_idx_t;

  typedef enum logic [2:0] {
    dir_local = 3'd0,
    dir_north = 3'd1,
    dir_east  = 3'd2,
    dir_south = 3'd3,
    dir_west  = 3'd4
  } route_dir_e;

  // One bit per port
  typedef logic [num_routes-1:0] port_mask_t;

  // Input buffering, depth must be a power of two for pointer wrap
  localparam int unsigned in_fifo_depth = 4;

  typedef logic [$clog2(in_fifo_depth)-1:0] fifo_ptr_t;
  typedef logic [$clog2(in_fifo_depth):0]   fifo_cnt_t;

endpackage

/* floo_route_xy.sv */
// ---------------------------------------------------------------------------
// Dimension-ordered XY route computation
// Resolves x first, then y, and returns Local once both coordinates match
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module floo_route_xy (
  input  floo_pkg::id_t        dst_i,
  input  floo_pkg::id_t        own_i,
  output floo_pkg::route_dir_e dir_o
);

  floo_pkg::coord_t dst_x;
  floo_pkg::coord_t dst_y;
  floo_pkg::coord_t own_x;
  floo_pkg::coord_t own_y;

  // Split ids into coordinates
  assign dst_x = dst_i[floo_pkg::coord_w-1:0];
  assign dst_y = dst_i[floo_pkg::id_w-1:floo_pkg::coord_w];
  assign own_x = own_i[floo_pkg::coord_w-1:0];
  assign own_y = own_i[floo_pkg::id_w-1:floo_pkg::coord_w];

  always_comb begin
    if (dst_x > own_x) begin
      dir_o = floo_pkg::dir_east;
    end else if (dst_x < own_x) begin
      dir_o = floo_pkg::dir_west;
    end else if (dst_y > own_y) begin
      // Same column, travel vertically
      dir_o = floo_pkg::dir_north;
    end else if (dst_y < own_y) begin
      dir_o = floo_pkg::dir_south;
    end else begin
      dir_o = floo_pkg::dir_local;
    end
  end

endmodule

/* floo_in_fifo.sv */
// ---------------------------------------------------------------------------
// Router input buffer
// Small circular FIFO with valid/ready on the link and on the head side
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module floo_in_fifo #(
  parameter int unsigned flit_w = floo_pkg::narrow_flit_w
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  output logic              ready_o,
  input  logic [flit_w-1:0] flit_i,
  output logic              valid_o,
  input  logic              ready_i,
  output logic [flit_w-1:0] flit_o
);

  logic [flit_w-1:0]   mem_q [floo_pkg::in_fifo_depth];
  floo_pkg::fifo_ptr_t wr_ptr_q;
  floo_pkg::fifo_ptr_t rd_ptr_q;
  floo_pkg::fifo_cnt_t count_q;
  logic                push;
  logic                pop;

  // Status comes straight from the registered count, a pop frees no slot this cycle
  assign ready_o = (count_q != floo_pkg::fifo_cnt_t'(floo_pkg::in_fifo_depth));
  assign valid_o = (count_q != '0);
  assign flit_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

endmodule

/* floo_out_arbiter.sv */
// ---------------------------------------------------------------------------
// Output port arbiter
// Round-robin choice among requesting inputs, flit mux and output register
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module floo_out_arbiter #(
  parameter int unsigned flit_w = floo_pkg::narrow_flit_w
) (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  floo_pkg::port_mask_t                       req_i,
  input  logic [floo_pkg::num_routes-1:0][flit_w-1:0] flit_i,
  output floo_pkg::port_mask_t                       gnt_o,
  output logic                                       valid_o,
  input  logic                                       ready_i,
  output logic [flit_w-1:0]                          flit_o
);

  logic                valid_q;
  logic [flit_w-1:0]   flit_q;
  floo_pkg::port_idx_t ptr_q;
  floo_pkg::port_idx_t next_ptr;
  floo_pkg::port_idx_t cand;
  floo_pkg::port_idx_t gnt_idx;
  logic                gnt_found;
  logic                load_en;

  // Register can take a new flit when empty or drained this cycle
  assign load_en = !valid_q || ready_i;

  // Search starts at the pointer and wraps around
  always_comb begin
    gnt_found = 1'b0;
    gnt_idx   = ptr_q;
    cand      = ptr_q;
    for (int k = 0; k < floo_pkg::num_routes; k++) begin
      cand = floo_pkg::port_idx_t'((int'(ptr_q) + k) % floo_pkg::num_routes);
      if (!gnt_found && req_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  assign gnt_o = (load_en && gnt_found) ? (floo_pkg::port_mask_t'(1) << gnt_idx) : '0;

  // Port after the winner gets priority next time
  assign next_ptr = (gnt_idx == floo_pkg::port_idx_t'(floo_pkg::num_routes - 1)) ?
                    '0 : gnt_idx + 1'b1;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      ptr_q   <= '0;
    end else if (load_en) begin
      valid_q <= gnt_found;
      if (gnt_found) begin
        ptr_q <= next_ptr;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_en && gnt_found) begin
      flit_q <= flit_i[gnt_idx];
    end
  end

  assign valid_o = valid_q;
  assign flit_o  = flit_q;

endmodule

/* floo_router.sv */
// ---------------------------------------------------------------------------
// Five-port router for one physical network
// Input FIFOs with XY route units feed one round-robin arbiter per output
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module floo_router #(
  parameter int unsigned flit_w = floo_pkg::narrow_flit_w
) (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  floo_pkg::id_t                              id_i,
  input  floo_pkg::port_mask_t                       valid_i,
  output floo_pkg::port_mask_t                       ready_o,
  input  logic [floo_pkg::num_routes-1:0][flit_w-1:0] flit_i,
  output floo_pkg::port_mask_t                       valid_o,
  input  floo_pkg::port_mask_t                       ready_i,
  output logic [floo_pkg::num_routes-1:0][flit_w-1:0] flit_o
);

  floo_pkg::port_mask_t                       head_valid;
  logic [floo_pkg::num_routes-1:0][flit_w-1:0] head_flit;
  floo_pkg::route_dir_e                       head_dir [floo_pkg::num_routes];
  floo_pkg::port_mask_t                       in_pop;
  // Indexed by output port, one bit per input
  floo_pkg::port_mask_t                       out_req [floo_pkg::num_routes];
  floo_pkg::port_mask_t                       out_gnt [floo_pkg::num_routes];

  for (genvar i = 0; i < floo_pkg::num_routes; i++) begin : gen_input
    floo_in_fifo #(
      .flit_w (flit_w)
    ) u_in_fifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .valid_i  (valid_i[i]),
      .ready_o  (ready_o[i]),
      .flit_i   (flit_i[i]),
      .valid_o  (head_valid[i]),
      .ready_i  (in_pop[i]),
      .flit_o   (head_flit[i])
    );

    // Destination id sits at the bottom of the header
    floo_route_xy u_route_xy (
      .dst_i (floo_pkg::id_t'(head_flit[i][floo_pkg::id_w-1:0])),
      .own_i (id_i),
      .dir_o (head_dir[i])
    );
  end

  // Each valid head requests exactly the output its route points to
  always_comb begin
    for (int j = 0; j < floo_pkg::num_routes; j++) begin
      out_req[j] = '0;
      for (int i = 0; i < floo_pkg::num_routes; i++) begin
        out_req[j][i] = head_valid[i] && (int'(head_dir[i]) == j);
      end
    end
  end

  // Pop an input when its arbiter takes the head flit
  always_comb begin
    in_pop = '0;
    for (int j = 0; j < floo_pkg::num_routes; j++) begin
      in_pop = in_pop | out_gnt[j];
    end
  end

  for (genvar j = 0; j < floo_pkg::num_routes; j++) begin : gen_output
    floo_out_arbiter #(
      .flit_w (flit_w)
    ) u_out_arbiter (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (out_req[j]),
      .flit_i   (head_flit),
      .gnt_o    (out_gnt[j]),
      .valid_o  (valid_o[j]),
      .ready_i  (ready_i[j]),
      .flit_o   (flit_o[j])
    );
  end

endmodule

/* floo_nw_router.sv */
// ---------------------------------------------------------------------------
// Mesh tile router top level
// Independent routers for narrow request, narrow response and wide networks
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module floo_nw_router (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  floo_pkg::id_t                                       id_i,
  // Narrow request network
  input  floo_pkg::port_mask_t                                req_valid_i,
  output floo_pkg::port_mask_t                                req_ready_o,
  input  floo_pkg::narrow_flit_t [floo_pkg::num_routes-1:0]   req_flit_i,
  output floo_pkg::port_mask_t                                req_valid_o,
  input  floo_pkg::port_mask_t                                req_ready_i,
  output floo_pkg::narrow_flit_t [floo_pkg::num_routes-1:0]   req_flit_o,
  // Narrow response network
  input  floo_pkg::port_mask_t                                rsp_valid_i,
  output floo_pkg::port_mask_t                                rsp_ready_o,
  input  floo_pkg::narrow_flit_t [floo_pkg::num_routes-1:0]   rsp_flit_i,
  output floo_pkg::port_mask_t                                rsp_valid_o,
  input  floo_pkg::port_mask_t                                rsp_ready_i,
  output floo_pkg::narrow_flit_t [floo_pkg::num_routes-1:0]   rsp_flit_o,
  // Wide network
  input  floo_pkg::port_mask_t                                wide_valid_i,
  output floo_pkg::port_mask_t                                wide_ready_o,
  input  floo_pkg::wide_flit_t [floo_pkg::num_routes-1:0]     wide_flit_i,
  output floo_pkg::port_mask_t                                wide_valid_o,
  input  floo_pkg::port_mask_t                                wide_ready_i,
  output floo_pkg::wide_flit_t [floo_pkg::num_routes-1:0]     wide_flit_o
);

  floo_router #(
    .flit_w (floo_pkg::narrow_flit_w)
  ) u_req_router (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .id_i     (id_i),
    .valid_i  (req_valid_i),
    .ready_o  (req_ready_o),
    .flit_i   (req_flit_i),
    .valid_o  (req_valid_o),
    .ready_i  (req_ready_i),
    .flit_o   (req_flit_o)
  );

  floo_router #(
    .flit_w (floo_pkg::narrow_flit_w)
  ) u_rsp_router (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .id_i     (id_i),
    .valid_i  (rsp_valid_i),
    .ready_o  (rsp_ready_o),
    .flit_i   (rsp_flit_i),
    .valid_o  (rsp_valid_o),
    .ready_i  (rsp_ready_i),
    .flit_o   (rsp_flit_o)
  );

  floo_router #(
    .flit_w (floo_pkg::wide_flit_w)
  ) u_wide_router (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .id_i     (id_i),
    .valid_i  (wide_valid_i),
    .ready_o  (wide_ready_o),
    .flit_i   (wide_flit_i),
    .valid_o  (wide_valid_o),
    .ready_i  (wide_ready_i),
    .flit_o   (wide_flit_o)
  );

endmodule

/* tb_floo_nw_router.sv */
// ---------------------------------------------------------------------------
// Testbench for the mesh tile router
// Drives the request, response and wide networks, models XY routing with
// one queue per network, output and source, and checks every delivered flit
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_floo_nw_router;

  localparam int unsigned num_nets = 3;
  localparam int unsigned max_w    = floo_pkg::wide_flit_w;
  localparam floo_pkg::id_t own_id = {3'd3, 3'd3};

  logic                                              clk_i;
  logic                                              arst_n_i;
  floo_pkg::port_mask_t                              in_valid [num_nets];
  floo_pkg::port_mask_t                              out_ready [num_nets];
  logic [max_w-1:0]                                  in_flit [num_nets][floo_pkg::num_routes];
  floo_pkg::port_mask_t                              req_ready_o;
  floo_pkg::port_mask_t                              rsp_ready_o;
  floo_pkg::port_mask_t                              wide_ready_o;
  floo_pkg::port_mask_t                              req_valid_o;
  floo_pkg::port_mask_t                              rsp_valid_o;
  floo_pkg::port_mask_t                              wide_valid_o;
  floo_pkg::narrow_flit_t [floo_pkg::num_routes-1:0] req_flit_i;
  floo_pkg::narrow_flit_t [floo_pkg::num_routes-1:0] rsp_flit_i;
  floo_pkg::wide_flit_t [floo_pkg::num_routes-1:0]   wide_flit_i;
  floo_pkg::narrow_flit_t [floo_pkg::num_routes-1:0] req_flit_o;
  floo_pkg::narrow_flit_t [floo_pkg::num_routes-1:0] rsp_flit_o;
  floo_pkg::wide_flit_t [floo_pkg::num_routes-1:0]   wide_flit_o;

  // Expected flits per network, output port and source port
  logic [max_w-1:0] exp_q [num_nets*25][$];
  int               seq [num_nets][floo_pkg::num_routes];
  int               errors;
  int               test_errs;
  int               tests_run;
  int               tests_failed;
  int               delivered;
  string            test_name;
  bit               log_local;
  int               local_log [$];

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  always_comb begin
    for (int p = 0; p < floo_pkg::num_routes; p++) begin
      req_flit_i[p]  = in_flit[0][p][floo_pkg::narrow_flit_w-1:0];
      rsp_flit_i[p]  = in_flit[1][p][floo_pkg::narrow_flit_w-1:0];
      wide_flit_i[p] = in_flit[2][p];
    end
  end

  floo_nw_router u_floo_nw_router (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .id_i         (own_id),
    .req_valid_i  (in_valid[0]),
    .req_ready_o  (req_ready_o),
    .req_flit_i   (req_flit_i),
    .req_valid_o  (req_valid_o),
    .req_ready_i  (out_ready[0]),
    .req_flit_o   (req_flit_o),
    .rsp_valid_i  (in_valid[1]),
    .rsp_ready_o  (rsp_ready_o),
    .rsp_flit_i   (rsp_flit_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (out_ready[1]),
    .rsp_flit_o   (rsp_flit_o),
    .wide_valid_i (in_valid[2]),
    .wide_ready_o (wide_ready_o),
    .wide_flit_i  (wide_flit_i),
    .wide_valid_o (wide_valid_o),
    .wide_ready_i (out_ready[2]),
    .wide_flit_o  (wide_flit_o)
  );

  function automatic void note_failure(string msg);
    $display("%s: %s", test_name, msg);
    errors++;
  endfunction

  function automatic void check_count(int expected, int actual);
    assert (actual == expected) else begin
      $display("FAILED %s: expected %0d, actual %0d", test_name, expected, actual);
      errors++;
    end
  endfunction

  // X is resolved before y
  function automatic int xy_port(floo_pkg::id_t dst);
    if (dst[2:0] > own_id[2:0]) return 2;
    if (dst[2:0] < own_id[2:0]) return 4;
    if (dst[5:3] > own_id[5:3]) return 1;
    if (dst[5:3] < own_id[5:3]) return 3;
    return 0;
  endfunction

  function automatic int q_idx(int net, int out, int src);
    return (net * 5 + out) * 5 + src;
  endfunction

  function automatic logic in_ready(int net, int port);
    case (net)
      0: return req_ready_o[port];
      1: return rsp_ready_o[port];
      default: return wide_ready_o[port];
    endcase
  endfunction

  function automatic logic out_valid(int net, int port);
    case (net)
      0: return req_valid_o[port];
      1: return rsp_valid_o[port];
      default: return wide_valid_o[port];
    endcase
  endfunction

  function automatic logic [max_w-1:0] flit_of(int net, int port);
    case (net)
      0: return max_w'(req_flit_o[port]);
      1: return max_w'(rsp_flit_o[port]);
      default: return wide_flit_o[port];
    endcase
  endfunction

  function automatic int pending(int net);
    int n;
    n = 0;
    for (int k = net * 25; k < net * 25 + 25; k++) begin
      n += exp_q[k].size();
    end
    return n;
  endfunction

  // Transfers happen at the next rising edge, so sample at the falling edge
  always @(negedge clk_i) begin : monitor
    logic [max_w-1:0] got;
    logic [max_w-1:0] exp;
    int               src;
    int               idx;
    if (arst_n_i) begin
      for (int n = 0; n < num_nets; n++) begin
        for (int p = 0; p < floo_pkg::num_routes; p++) begin
          if (in_valid[n][p] && in_ready(n, p)) begin
            exp_q[q_idx(n, xy_port(in_flit[n][p][5:0]), p)].push_back(in_flit[n][p]);
          end
          if (out_valid(n, p) && out_ready[n][p]) begin
            got = flit_of(n, p);
            src = int'(got[30:28]);
            idx = q_idx(n, p, src);
            delivered++;
            if (n == 0 && p == 0 && log_local) begin
              local_log.push_back(src);
            end
            if (src >= 5 || exp_q[idx].size() == 0) begin
              note_failure($sformatf("unexpected flit on network %0d port %0d", n, p));
            end else begin
              exp = exp_q[idx].pop_front();
              assert (got == exp) else begin
                $display("FAILED %s: expected %h, actual %h", test_name, exp, got);
                errors++;
              end
            end
          end
        end
      end
    end
  end

  assert property (@(posedge clk_i) !arst_n_i |->
    (req_valid_o | rsp_valid_o | wide_valid_o) == '0 &&
    (req_ready_o & rsp_ready_o & wide_ready_o) == '1)
    else note_failure("outputs not idle during reset");

  // A stalled output keeps its flit
  for (genvar p = 0; p < floo_pkg::num_routes; p++) begin : gen_hold_chk
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      req_valid_o[p] && !out_ready[0][p] |=> req_valid_o[p] && $stable(req_flit_o[p]))
      else note_failure("request output changed while stalled");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rsp_valid_o[p] && !out_ready[1][p] |=> rsp_valid_o[p] && $stable(rsp_flit_o[p]))
      else note_failure("response output changed while stalled");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wide_valid_o[p] && !out_ready[2][p] |=> wide_valid_o[p] && $stable(wide_flit_o[p]))
      else note_failure("wide output changed while stalled");
  end

  // Payload carries sequence number and source port for the checker
  task automatic send_flit(int net, int port, floo_pkg::id_t dst);
    logic [max_w-1:0] f;
    int               waited;
    f        = max_w'({$urandom, $urandom, $urandom});
    f[5:0]   = dst;
    f[27:12] = 16'(seq[net][port]);
    f[30:28] = 3'(port);
    if (net < 2) begin
      f[max_w-1:floo_pkg::narrow_flit_w] = '0;
    end
    seq[net][port]++;
    waited = 0;
    in_flit[net][port]  = f;
    in_valid[net][port] = 1'b1;
    @(negedge clk_i);
    while (!in_ready(net, port) && waited < 500) begin
      waited++;
      @(negedge clk_i);
    end
    if (waited >= 500) begin
      note_failure($sformatf("input %0d of network %0d never became ready", port, net));
    end
    @(posedge clk_i);
    #1;
    in_valid[net][port] = 1'b0;
  endtask

  task automatic wait_drained(int net, int limit);
    int waited;
    waited = 0;
    while (pending(net) != 0 && waited < limit) begin
      waited++;
      @(posedge clk_i);
      #1;
    end
    if (pending(net) != 0) begin
      note_failure($sformatf("network %0d still holds %0d flits", net, pending(net)));
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic random_stream(int net, int port, int count);
    for (int k = 0; k < count; k++) begin
      if ($urandom % 2 == 0) begin
        @(posedge clk_i);
        #1;
      end
      send_flit(net, port, floo_pkg::id_t'($urandom));
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errs = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_errs) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - test_errs);
    end
  endtask

  initial begin
    int offs [3];
    int sent;
    int cycles;
    bit stalls_on;
    void'($urandom(68));
    arst_n_i     = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    delivered    = 0;
    log_local    = 1'b0;
    offs         = '{1, 3, 6};
    for (int n = 0; n < num_nets; n++) begin
      in_valid[n]  = '0;
      out_ready[n] = '1;
      for (int p = 0; p < floo_pkg::num_routes; p++) begin
        in_flit[n][p] = '0;
        seq[n][p]     = 0;
      end
    end

    start_test("reset_state");
    repeat (10) begin
      @(posedge clk_i);
      #1;
      assert ((req_valid_o | rsp_valid_o | wide_valid_o) == '0 &&
              (req_ready_o & rsp_ready_o & wide_ready_o) == '1)
        else note_failure("outputs not idle while reset is held");
    end
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #1;
    assert ((req_valid_o | rsp_valid_o | wide_valid_o) == '0 &&
            (req_ready_o & rsp_ready_o & wide_ready_o) == '1)
      else note_failure("outputs not idle after reset release");
    finish_test();

    // Every input, every network, destinations on all sides and the own tile
    start_test("xy_routing");
    for (int n = 0; n < num_nets; n++) begin
      for (int p = 0; p < floo_pkg::num_routes; p++) begin
        for (int a = 0; a < 3; a++) begin
          for (int b = 0; b < 3; b++) begin
            send_flit(n, p, {3'(offs[b]), 3'(offs[a])});
            wait_drained(n, 20);
          end
        end
      end
    end
    finish_test();

    start_test("net_independence");
    out_ready[0][2] = 1'b0;
    fork
      send_flit(0, 0, {3'd3, 3'd5});
      send_flit(1, 0, {3'd3, 3'd5});
      send_flit(2, 0, {3'd3, 3'd5});
    join
    wait_drained(1, 50);
    wait_drained(2, 50);
    // Request flit waits in the stalled East output register
    check_count(1, int'(req_valid_o[2]));
    out_ready[0][2] = 1'b1;
    wait_drained(0, 50);
    finish_test();

    // Input FIFO plus the output register can absorb the stream
    start_test("backpressure");
    out_ready[0][1] = 1'b0;
    sent = 0;
    while (in_ready(0, 0) && sent < 20) begin
      send_flit(0, 0, {3'd6, 3'd3});
      sent++;
    end
    check_count(floo_pkg::in_fifo_depth + 1, sent);
    out_ready[0][1] = 1'b1;
    wait_drained(0, 50);
    finish_test();

    start_test("round_robin");
    local_log.delete();
    log_local = 1'b1;
    fork
      repeat (8) send_flit(0, 4, own_id);
      repeat (8) send_flit(0, 3, own_id);
    join
    wait_drained(0, 50);
    log_local = 1'b0;
    check_count(16, local_log.size());
    for (int k = 1; k < local_log.size(); k++) begin
      check_count((local_log[k-1] == 3) ? 4 : 3, local_log[k]);
    end
    finish_test();

    start_test("random_traffic");
    stalls_on = 1'b1;
    fork
      begin
        for (int n = 0; n < num_nets; n++) begin
          for (int p = 0; p < floo_pkg::num_routes; p++) begin
            fork
              automatic int fn = n;
              automatic int fp = p;
              random_stream(fn, fp, 12);
            join_none
          end
        end
        wait fork;
        stalls_on = 1'b0;
      end
      begin
        cycles = 0;
        while (stalls_on && cycles < 5000) begin
          for (int n = 0; n < num_nets; n++) begin
            // Two random words ORed keep each ready high three cycles in four
            out_ready[n] = floo_pkg::port_mask_t'($urandom) | floo_pkg::port_mask_t'($urandom);
          end
          cycles++;
          @(posedge clk_i);
          #1;
        end
        if (stalls_on) begin
          note_failure("random streams did not finish in time");
        end
        for (int n = 0; n < num_nets; n++) begin
          out_ready[n] = '1;
        end
      end
    join
    for (int n = 0; n < num_nets; n++) begin
      wait_drained(n, 200);
    end
    finish_test();

    $display("tests run %0d, failed %0d, flits checked %0d, errors %0d",
             tests_run, tests_failed, delivered, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* build.f */
floo_pkg.sv
floo_route_xy.sv
floo_in_fifo.sv
floo_out_arbiter.sv
floo_router.sv
floo_nw_router.sv
tb_floo_nw_router.sv
